/* common/cpu_pkg.sv */
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;

	localparam word_t ZERO_WORD = 32'h0000_0000;

	// executed operation, shared by decode and execute
	typedef enum logic [4:0] {
		OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_SLT, OP_SLTU, OP_SLL, OP_SRL, OP_SRA, OP_LUI,
		OP_MOVZ, OP_MOVN, OP_JAL, OP_NOP, OP_INVALID
	} oper_t;

	// R layout of an instruction word
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} inst_r_t;

	// I layout, same word read with a 16-bit immediate
	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} inst_i_t;

	typedef union packed {
		inst_r_t r;
		inst_i_t i;
	} inst_t;

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} reg_wr_t;

	typedef struct packed {
		logic  valid;
		word_t pc;
		inst_t inst;
	} if_data_t;

	typedef struct packed {
		logic       valid;
		oper_t      op;
		word_t      pc;
		word_t      reg1;
		word_t      reg2;
		word_t      imm;
		logic [4:0] shamt;
		logic       we;
		reg_addr_t  waddr;
	} id_data_t;

	localparam logic [5:0] OPC_SPECIAL = 6'h00;
	localparam logic [5:0] OPC_J       = 6'h02;
	localparam logic [5:0] OPC_JAL     = 6'h03;
	localparam logic [5:0] OPC_ADDIU   = 6'h09;
	localparam logic [5:0] OPC_SLTI    = 6'h0a;
	localparam logic [5:0] OPC_SLTIU   = 6'h0b;
	localparam logic [5:0] OPC_ANDI    = 6'h0c;
	localparam logic [5:0] OPC_ORI     = 6'h0d;
	localparam logic [5:0] OPC_XORI    = 6'h0e;
	localparam logic [5:0] OPC_LUI     = 6'h0f;

	// SPECIAL funct field
	localparam logic [5:0] FN_SLL  = 6'h00;
	localparam logic [5:0] FN_SRL  = 6'h02;
	localparam logic [5:0] FN_SRA  = 6'h03;
	localparam logic [5:0] FN_MOVZ = 6'h0a;
	localparam logic [5:0] FN_MOVN = 6'h0b;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

endpackage

/* src/inst_fetch.sv */
`timescale 1ns/1ps

module inst_fetch (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             inst_req_i,
	input  cpu_pkg::word_t   inst_i,
	input  cpu_pkg::word_t   pc_i,
	output logic             inst_ack_o,
	output cpu_pkg::if_data_t if_o
);

	import cpu_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_ACKED
	} state_t;

	state_t state_q;
	logic   valid_q;
	word_t  pc_q;
	inst_t  inst_q;

	// four-phase handshake, ack mirrors the acked state
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= S_IDLE;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			case (state_q)
				S_IDLE: begin
					if (inst_req_i) begin
						state_q <= S_ACKED;
						valid_q <= 1'b1;
					end
				end
				S_ACKED: begin
					// wait for the source to release req
					if (!inst_req_i) begin
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// capture word and pc on entry to the acked state
	always_ff @(posedge clk_i) begin
		if (state_q == S_IDLE && inst_req_i) begin
			pc_q   <= pc_i;
			inst_q <= inst_i;
		end
	end

	assign inst_ack_o = (state_q == S_ACKED);

	assign if_o.valid = valid_q;
	assign if_o.pc    = pc_q;
	assign if_o.inst  = inst_q;

endmodule

/* decode/cpu_id.sv */
`timescale 1ns/1ps

module cpu_id (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  cpu_pkg::if_data_t   if_i,
	input  cpu_pkg::word_t      reg1_i,
	input  cpu_pkg::word_t      reg2_i,
	input  cpu_pkg::reg_wr_t    wb_i,
	output cpu_pkg::reg_addr_t  reg_raddr1_o,
	output cpu_pkg::reg_addr_t  reg_raddr2_o,
	output cpu_pkg::id_data_t   id_o
);

	import cpu_pkg::*;

	inst_t     inst;
	logic [5:0] opcode;
	oper_t     op;
	word_t     imm;
	word_t     safe_reg1;
	word_t     safe_reg2;
	word_t     reg2_sel;
	logic      reg_we;
	reg_addr_t reg_waddr;
	logic      cond_move_not_taken;
	id_data_t  id_q;

	assign inst   = if_i.inst;
	assign opcode = inst.r.opcode;

	// format decode and register addresses
	always_comb begin
		op           = OP_INVALID;
		reg_raddr1_o = '0;
		reg_raddr2_o = '0;
		reg_waddr    = '0;
		reg_we       = 1'b0;
		imm          = ZERO_WORD;
		case (opcode)
			OPC_SPECIAL: begin
				reg_raddr1_o = inst.r.rs;
				reg_raddr2_o = inst.r.rt;
				reg_waddr    = inst.r.rd;
				reg_we       = 1'b1;
				case (inst.r.funct)
					FN_ADD, FN_ADDU: op = OP_ADD;
					FN_SUB, FN_SUBU: op = OP_SUB;
					FN_AND:          op = OP_AND;
					FN_OR:           op = OP_OR;
					FN_XOR:          op = OP_XOR;
					FN_NOR:          op = OP_NOR;
					FN_SLT:          op = OP_SLT;
					FN_SLTU:         op = OP_SLTU;
					FN_SLL:          op = OP_SLL;
					FN_SRL:          op = OP_SRL;
					FN_SRA:          op = OP_SRA;
					FN_MOVZ:         op = OP_MOVZ;
					FN_MOVN:         op = OP_MOVN;
					default: begin
						op     = OP_INVALID;
						reg_we = 1'b0;
					end
				endcase
				// all-zero word is the canonical nop
				if (inst == '0) begin
					op     = OP_NOP;
					reg_we = 1'b0;
				end
			end
			OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI: begin
				reg_raddr1_o = inst.i.rs;
				reg_waddr    = inst.i.rt;
				reg_we       = 1'b1;
				imm          = {{16{inst.i.imm[15]}}, inst.i.imm};
				case (opcode)
					OPC_ADDIU: op = OP_ADD;
					OPC_SLTI:  op = OP_SLT;
					OPC_SLTIU: op = OP_SLTU;
					OPC_ANDI:  op = OP_AND;
					OPC_ORI:   op = OP_OR;
					OPC_XORI:  op = OP_XOR;
					default:   op = OP_LUI;
				endcase
				// logical immediates are zero extended
				if (opcode == OPC_ANDI || opcode == OPC_ORI || opcode == OPC_XORI) begin
					imm = {16'h0000, inst.i.imm};
				end
				if (opcode == OPC_LUI) begin
					imm = {inst.i.imm, 16'h0000};
				end
			end
			OPC_J: begin
				// no control flow here, J retires without a write
				op = OP_NOP;
			end
			OPC_JAL: begin
				op        = OP_JAL;
				reg_waddr = 5'd31;
				reg_we    = 1'b1;
			end
			default: op = OP_INVALID;
		endcase
	end

	// writeback bypass, $0 always reads zero
	always_comb begin
		if (reg_raddr1_o == '0) begin
			safe_reg1 = ZERO_WORD;
		end else if (wb_i.we && wb_i.waddr == reg_raddr1_o) begin
			safe_reg1 = wb_i.wdata;
		end else begin
			safe_reg1 = reg1_i;
		end

		if (reg_raddr2_o == '0) begin
			safe_reg2 = ZERO_WORD;
		end else if (wb_i.we && wb_i.waddr == reg_raddr2_o) begin
			safe_reg2 = wb_i.wdata;
		end else begin
			safe_reg2 = reg2_i;
		end
	end

	// conditional moves test rt
	assign cond_move_not_taken = (op == OP_MOVZ && safe_reg2 != ZERO_WORD) ||
		(op == OP_MOVN && safe_reg2 == ZERO_WORD);

	// I-type replaces the second operand with the immediate
	assign reg2_sel = (opcode == OPC_SPECIAL) ? safe_reg2 : imm;

	// ID/EX register
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			id_q.valid <= 1'b0;
		end else begin
			id_q.valid <= if_i.valid;
		end
		if (if_i.valid) begin
			id_q.op    <= op;
			id_q.pc    <= if_i.pc;
			id_q.reg1  <= safe_reg1;
			id_q.reg2  <= reg2_sel;
			id_q.imm   <= imm;
			id_q.shamt <= inst.r.shamt;
			id_q.we    <= reg_we & ~cond_move_not_taken;
			id_q.waddr <= reg_waddr;
		end
	end

	assign id_o = id_q;

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ps

module reg_file #(
	parameter int NUM_REGS = 32
) (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  cpu_pkg::reg_addr_t raddr1_i,
	input  cpu_pkg::reg_addr_t raddr2_i,
	input  cpu_pkg::reg_wr_t   wr_i,
	output cpu_pkg::word_t     rdata1_o,
	output cpu_pkg::word_t     rdata2_o
);

	import cpu_pkg::*;

	word_t regs [0:NUM_REGS-1];

	// $0 is never written, so it keeps its reset value
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= ZERO_WORD;
			end
		end else if (wr_i.we && wr_i.waddr != '0 && wr_i.waddr < NUM_REGS) begin
			regs[wr_i.waddr] <= wr_i.wdata;
		end
	end

	// addresses past the array read as zero
	assign rdata1_o = (raddr1_i < NUM_REGS) ? regs[raddr1_i] : ZERO_WORD;
	assign rdata2_o = (raddr2_i < NUM_REGS) ? regs[raddr2_i] : ZERO_WORD;

endmodule

/* src/cpu_ex.sv */
`timescale 1ns/1ps

module cpu_ex (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  cpu_pkg::id_data_t id_i,
	output cpu_pkg::reg_wr_t  wb_o
);

	import cpu_pkg::*;

	word_t   alu_res;
	reg_wr_t wb_q;

	// ALU, reg2 already holds the immediate for I-type
	always_comb begin
		case (id_i.op)
			OP_ADD:  alu_res = id_i.reg1 + id_i.reg2;
			OP_SUB:  alu_res = id_i.reg1 - id_i.reg2;
			OP_AND:  alu_res = id_i.reg1 & id_i.reg2;
			OP_OR:   alu_res = id_i.reg1 | id_i.reg2;
			OP_XOR:  alu_res = id_i.reg1 ^ id_i.reg2;
			OP_NOR:  alu_res = ~(id_i.reg1 | id_i.reg2);
			OP_SLT: begin
				alu_res = {31'b0, $signed(id_i.reg1) < $signed(id_i.reg2)};
			end
			OP_SLTU: begin
				alu_res = {31'b0, id_i.reg1 < id_i.reg2};
			end
			// shifts act on rt by shamt
			OP_SLL:  alu_res = id_i.reg2 << id_i.shamt;
			OP_SRL:  alu_res = id_i.reg2 >> id_i.shamt;
			OP_SRA:  alu_res = word_t'($signed(id_i.reg2) >>> id_i.shamt);
			OP_LUI:  alu_res = id_i.imm;
			// condition was resolved in decode
			OP_MOVZ, OP_MOVN: alu_res = id_i.reg1;
			// return address skips the delay slot
			OP_JAL:  alu_res = id_i.pc + 32'd8;
			default: alu_res = ZERO_WORD;
		endcase
	end

	// EX/WB register
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wb_q.we <= 1'b0;
		end else begin
			wb_q.we <= id_i.valid & id_i.we;
		end
		wb_q.waddr <= id_i.waddr;
		wb_q.wdata <= alu_res;
	end

	assign wb_o = wb_q;

endmodule

/* src/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter int NUM_REGS = 32
) (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  logic             inst_req_i,
	input  cpu_pkg::word_t   inst_i,
	input  cpu_pkg::word_t   pc_i,
	output logic             inst_ack_o,
	output cpu_pkg::reg_wr_t wb_o
);

	import cpu_pkg::*;

	if_data_t  if_data;
	id_data_t  id_data;
	reg_addr_t reg_raddr1;
	reg_addr_t reg_raddr2;
	word_t     reg_rdata1;
	word_t     reg_rdata2;

	inst_fetch u_inst_fetch (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.inst_req_i (inst_req_i),
		.inst_i     (inst_i),
		.pc_i       (pc_i),
		.inst_ack_o (inst_ack_o),
		.if_o       (if_data)
	);

	cpu_id u_cpu_id (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.if_i         (if_data),
		.reg1_i       (reg_rdata1),
		.reg2_i       (reg_rdata2),
		.wb_i         (wb_o),
		.reg_raddr1_o (reg_raddr1),
		.reg_raddr2_o (reg_raddr2),
		.id_o         (id_data)
	);

	// writeback feeds the array, the bypass and the port
	reg_file #(
		.NUM_REGS (NUM_REGS)
	) u_reg_file (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.raddr1_i (reg_raddr1),
		.raddr2_i (reg_raddr2),
		.wr_i     (wb_o),
		.rdata1_o (reg_rdata1),
		.rdata2_o (reg_rdata2)
	);

	cpu_ex u_cpu_ex (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.id_i    (id_data),
		.wb_o    (wb_o)
	);

endmodule

/* tests/cpu_asserts.sv */
`timescale 1ns/1ps

module cpu_asserts (
	input logic             clk_i,
	input logic             rst_n_i,
	input logic             inst_req_i,
	input logic             inst_ack_i,
	input cpu_pkg::reg_wr_t wb_i
);

	// read by the testbench at the end of the run
	int unsigned fail_cnt = 0;

	// reset leaves the port and writeback idle
	assert property (@(posedge clk_i) !rst_n_i |=> !inst_ack_i && !wb_i.we)
		else begin
			$error("ack or writeback active right after reset");
			fail_cnt++;
		end

	// idle with a pending req acks on the next clock
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!inst_ack_i && inst_req_i |=> inst_ack_i)
		else begin
			$error("ack did not rise one clock after req");
			fail_cnt++;
		end

	// ack falls on the clock after req falls
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		inst_ack_i && !inst_req_i |=> !inst_ack_i)
		else begin
			$error("ack did not fall one clock after req fell");
			fail_cnt++;
		end

	// no ack without a req
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!inst_ack_i && !inst_req_i |=> !inst_ack_i)
		else begin
			$error("ack rose without a req");
			fail_cnt++;
		end

	// every write belongs to the ack that rose two clocks before
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_i.we |-> $past(inst_ack_i, 2) && !$past(inst_ack_i, 3))
		else begin
			$error("writeback not two clocks after an ack rise");
			fail_cnt++;
		end

	assert property (@(posedge clk_i) disable iff (!rst_n_i) wb_i.we |=> !wb_i.we)
		else begin
			$error("writeback enable longer than one clock");
			fail_cnt++;
		end

endmodule

bind cpu_top cpu_asserts u_cpu_asserts (
	.clk_i      (clk_i),
	.rst_n_i    (rst_n_i),
	.inst_req_i (inst_req_i),
	.inst_ack_i (inst_ack_o),
	.wb_i       (wb_o)
);

/* tests/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

	import cpu_pkg::*;

	localparam int TIMEOUT = 40;
	localparam int MAX_WR  = 128;

	logic    clk = 1'b0;
	logic    rst_n;
	logic    inst_req;
	word_t   inst;
	word_t   pc_in;
	logic    inst_ack;
	reg_wr_t wb;

	word_t     shadow [0:31];
	reg_addr_t exp_waddr [0:MAX_WR-1];
	word_t     exp_wdata [0:MAX_WR-1];
	int        exp_cnt = 0;
	int        wb_cnt = 0;
	int        wb_err_cnt = 0;
	int        other_cnt = 0;
	word_t     pc;

	cpu_top #(
		.NUM_REGS (32)
	) dut_i (
		.clk_i      (clk),
		.rst_n_i    (rst_n),
		.inst_req_i (inst_req),
		.inst_i     (inst),
		.pc_i       (pc_in),
		.inst_ack_o (inst_ack),
		.wb_o       (wb)
	);

	always #2 clk = ~clk;

	// index of the next expected write
	always @(posedge clk) begin
		if (wb.we === 1'b1) begin
			wb_cnt <= wb_cnt + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) wb.we |-> wb_cnt < exp_cnt)
		else begin
			$display("unexpected writeback pulse at %0t", $time);
			wb_err_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		wb.we |-> wb.waddr == exp_waddr[wb_cnt])
		else begin
			$display("mismatch at %0t: wb_o.waddr got %0d expected %0d", $time,
				$sampled(wb.waddr), exp_waddr[$sampled(wb_cnt)]);
			wb_err_cnt++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		wb.we |-> wb.wdata == exp_wdata[wb_cnt])
		else begin
			$display("mismatch at %0t: wb_o.wdata got %h expected %h", $time,
				$sampled(wb.wdata), exp_wdata[$sampled(wb_cnt)]);
			wb_err_cnt++;
		end

	// queue a predicted write, $0 keeps zero in the model
	task automatic expect_wr(input reg_addr_t addr, input word_t data);
		exp_waddr[exp_cnt] = addr;
		exp_wdata[exp_cnt] = data;
		exp_cnt++;
		if (addr != 5'd0) begin
			shadow[addr] = data;
		end
	endtask

	// one four-phase transfer, ends with ack low
	task automatic send(input word_t word);
		int t;
		@(posedge clk);
		inst_req <= 1'b1;
		inst     <= word;
		pc_in    <= pc;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (!inst_ack && t < TIMEOUT);
		if (!inst_ack) begin
			$display("timeout waiting for ack to rise at pc %h", pc);
			other_cnt++;
		end
		@(posedge clk);
		inst_req <= 1'b0;
		t = 0;
		do begin
			@(negedge clk);
			t++;
		end while (inst_ack && t < TIMEOUT);
		if (inst_ack) begin
			$display("timeout waiting for ack to fall at pc %h", pc);
			other_cnt++;
		end
		pc = pc + 32'd4;
	endtask

	task automatic run_r(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd, input logic [4:0] sh);
		word_t a;
		word_t b;
		word_t r;
		logic  wr;
		a = shadow[rs];
		b = shadow[rt];
		wr = 1'b1;
		case (fn)
			FN_ADD:  r = a + b;
			FN_SUB:  r = a - b;
			FN_AND:  r = a & b;
			FN_OR:   r = a | b;
			FN_XOR:  r = a ^ b;
			FN_NOR:  r = ~(a | b);
			FN_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLTU: r = (a < b) ? 32'd1 : 32'd0;
			FN_SLL:  r = b << sh;
			FN_SRL:  r = b >> sh;
			FN_SRA:  r = $signed(b) >>> sh;
			// moves write rs only when the rt test holds
			FN_MOVZ: begin
				r = a;
				wr = (b == 32'd0);
			end
			FN_MOVN: begin
				r = a;
				wr = (b != 32'd0);
			end
			default: r = 32'd0;
		endcase
		if (wr) begin
			expect_wr(rd, r);
		end
		send({OPC_SPECIAL, rs, rt, rd, sh, fn});
	endtask

	task automatic run_i(input logic [5:0] opc, input reg_addr_t rs, input reg_addr_t rt,
		input logic [15:0] imm);
		word_t a;
		word_t sx;
		word_t zx;
		word_t r;
		a = shadow[rs];
		sx = {{16{imm[15]}}, imm};
		zx = {16'h0000, imm};
		case (opc)
			OPC_ADDIU: r = a + sx;
			OPC_SLTI:  r = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
			OPC_SLTIU: r = (a < sx) ? 32'd1 : 32'd0;
			OPC_ANDI:  r = a & zx;
			OPC_ORI:   r = a | zx;
			OPC_XORI:  r = a ^ zx;
			default:   r = {imm, 16'h0000};
		endcase
		expect_wr(rt, r);
		send({opc, rs, rt, imm});
	endtask

	task automatic load_reg(input reg_addr_t rd, input word_t value);
		run_i(OPC_LUI, 5'd0, rd, value[31:16]);
		run_i(OPC_ORI, rd, rd, value[15:0]);
	endtask

	initial begin
		int         t;
		logic [5:0] fns [0:10] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR,
			FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
		logic [5:0] opcs [0:6] = '{OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI, OPC_ORI,
			OPC_XORI, OPC_LUI};
		void'($urandom(32'h1a36));
		rst_n = 1'b0;
		inst_req = 1'b0;
		inst = 32'h0;
		pc_in = 32'h0;
		pc = 32'h0040_0000;
		for (int i = 0; i < 32; i++) begin
			shadow[i] = 32'h0;
		end
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		for (int i = 1; i <= 8; i++) begin
			load_reg(reg_addr_t'(i), $urandom());
		end
		for (int k = 0; k < 11; k++) begin
			run_r(fns[k], reg_addr_t'($urandom_range(1, 8)), reg_addr_t'($urandom_range(1, 8)),
				reg_addr_t'(9 + k), 5'($urandom_range(0, 31)));
		end
		// bit 15 set tells zero from sign extension
		for (int k = 0; k < 7; k++) begin
			run_i(opcs[k], reg_addr_t'($urandom_range(1, 8)), reg_addr_t'(20 + k),
				16'h8000 | 16'($urandom()));
		end

		// each result feeds the next instruction
		run_r(FN_ADD, 5'd1, 5'd2, 5'd10, 5'd0);
		run_r(FN_SUB, 5'd10, 5'd3, 5'd11, 5'd0);
		run_i(OPC_XORI, 5'd11, 5'd11, 16'hbeef);
		run_r(FN_OR, 5'd11, 5'd10, 5'd12, 5'd0);

		run_i(OPC_ORI, 5'd0, 5'd13, 16'h0000);
		run_i(OPC_ORI, 5'd0, 5'd14, 16'h0007);
		run_r(FN_MOVZ, 5'd1, 5'd13, 5'd15, 5'd0);
		run_r(FN_MOVZ, 5'd2, 5'd14, 5'd15, 5'd0);
		run_r(FN_MOVN, 5'd3, 5'd14, 5'd16, 5'd0);
		run_r(FN_MOVN, 5'd4, 5'd13, 5'd16, 5'd0);

		// $0 takes the pulse but keeps zero
		run_i(OPC_ADDIU, 5'd1, 5'd0, 16'h1234);
		run_r(FN_OR, 5'd0, 5'd0, 5'd17, 5'd0);
		run_r(FN_ADD, 5'd0, 5'd1, 5'd18, 5'd0);
		expect_wr(5'd31, pc + 32'd8);
		send({OPC_JAL, 26'h010_0000});
		run_r(FN_ADD, 5'd31, 5'd0, 5'd19, 5'd0);

		t = 0;
		while (wb_cnt != exp_cnt && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		repeat (3) @(negedge clk);
		assert (wb_cnt == exp_cnt)
			else begin
				$display("only %0d of %0d expected writebacks appeared", wb_cnt, exp_cnt);
				other_cnt++;
			end

		$display("writebacks %0d, writeback errors %0d, other errors %0d, protocol failures %0d",
			wb_cnt, wb_err_cnt, other_cnt, dut_i.u_cpu_asserts.fail_cnt);
		if (wb_err_cnt == 0 && other_cnt == 0 && dut_i.u_cpu_asserts.fail_cnt == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

/* files.f */
common/cpu_pkg.sv
src/inst_fetch.sv
decode/cpu_id.sv
src/reg_file.sv
src/cpu_ex.sv
src/cpu_top.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
